/* design/clock_pkg.sv */
`default_nettype none

package clock_pkg;

	// --------------------
	// widths with a meaning
	typedef logic [5:0] field_t;   // 0..59 or 0..23
	typedef logic [3:0] digit_t;   // one bcd digit
	typedef logic [6:0] seg_t;     // a..g, msb = a, active high
	typedef logic [5:0] dig_en_t;  // active low, bit 0 = seconds ones

	// press order matters, the FSMs step through these
	typedef enum logic [1:0] {
		MODE_CLOCK,
		MODE_SETUP,
		MODE_ALARM
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HR
	} pos_e;

	typedef struct packed {
		field_t hr;
		field_t min;
		field_t sec;
	} hms_s;

	typedef struct packed {
		mode_e  mode;
		pos_e   pos;
		logic   alarm_en;
		logic   inc;       // one-cycle pulse per press
	} cmd_s;

	// --------------------
	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HR_MAX  = 6'd23;

	// digits 0..9
	localparam seg_t SEG_TABLE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

`default_nettype wire

/* design/tick_gen.sv */
`default_nettype none

module tick_gen #(
	parameter int DIV = 4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	// free running from reset, tick on the last count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			if (cnt == CW'(DIV - 1)) begin
				cnt    <= '0;
				o_tick <= 1'b1;  // high for exactly one clk
			end else begin
				cnt    <= cnt + 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* design/button_decode.sv */
`default_nettype none

module button_decode #(
	parameter int SAMPLE_DIV = 500_000
) (
	input  wire            clk,
	input  wire            rst_n,
	input  wire            i_sw_mode,
	input  wire            i_sw_pos,
	input  wire            i_sw_inc,
	input  wire            i_sw_alarm,
	output clock_pkg::cmd_s o_cmd
);

	import clock_pkg::*;

	// bit positions in the button vectors
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic       sample_tick;
	logic       tick_d;       // sample tick, one clk late
	logic [3:0] sw_now;
	logic [3:0] smp0;         // newest sample
	logic [3:0] smp1;         // sample before that
	logic [3:0] deb;          // debounced level
	logic [3:0] press;

	mode_e mode_q;
	pos_e  pos_q;
	logic  alarm_en_q;

	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	assign sw_now = {i_sw_alarm, i_sw_inc, i_sw_pos, i_sw_mode};

	// --------------------
	// sampling and debounce
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp0   <= '0;
			smp1   <= '0;
			deb    <= '0;
			tick_d <= 1'b0;
		end else begin
			tick_d <= sample_tick;
			if (sample_tick) begin
				smp0 <= sw_now;
				smp1 <= smp0;
			end
			// two highs set it, two lows clear it, mixed keeps it
			if (tick_d)
				deb <= (smp0 & smp1) | (deb & (smp0 | smp1));
		end
	end

	// new press, valid in the clk after the second high sample
	assign press = {4{tick_d}} & smp0 & smp1 & ~deb;

	// --------------------
	// mode / position FSMs and alarm enable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			alarm_en_q <= 1'b0;
		end else begin
			if (press[BTN_MODE]) begin
				case (mode_q)
					MODE_CLOCK: mode_q <= MODE_SETUP;
					MODE_SETUP: mode_q <= MODE_ALARM;
					default:    mode_q <= MODE_CLOCK;
				endcase
			end
			if (press[BTN_POS]) begin
				case (pos_q)
					POS_SEC: pos_q <= POS_MIN;
					POS_MIN: pos_q <= POS_HR;
					default: pos_q <= POS_SEC;
				endcase
			end
			if (press[BTN_ALARM])
				alarm_en_q <= ~alarm_en_q;
		end
	end

	assign o_cmd = '{
		mode:     mode_q,
		pos:      pos_q,
		alarm_en: alarm_en_q,
		inc:      press[BTN_INC]
	};

endmodule

`default_nettype wire

/* design/time_execute.sv */
`default_nettype none

module time_execute #(
	parameter int TICK_DIV = 50_000_000
) (
	input  wire             clk,
	input  wire             rst_n,
	input  clock_pkg::cmd_s i_cmd,
	output clock_pkg::hms_s o_show,
	output logic            o_alarm
);

	import clock_pkg::*;

	logic sec_tick;
	hms_s clk_t;    // time of day
	hms_s alm_t;    // alarm time
	hms_s show_q;
	logic alarm_q;
	logic match;

	tick_gen #(.DIV(TICK_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	// --------------------
	// field helpers
	function automatic field_t wrap_inc(field_t f, field_t max_v);
		return (f >= max_v) ? '0 : f + 6'd1;
	endfunction

	// one second forward with carries
	function automatic hms_s hms_step(hms_s t);
		hms_s n;
		n     = t;
		n.sec = wrap_inc(t.sec, SEC_MAX);
		if (t.sec == SEC_MAX) begin
			n.min = wrap_inc(t.min, MIN_MAX);
			if (t.min == MIN_MAX)
				n.hr = wrap_inc(t.hr, HR_MAX);
		end
		return n;
	endfunction

	// setting, selected field only, no carry
	function automatic hms_s hms_bump(hms_s t, pos_e p);
		hms_s n;
		n = t;
		case (p)
			POS_SEC: n.sec = wrap_inc(t.sec, SEC_MAX);
			POS_MIN: n.min = wrap_inc(t.min, MIN_MAX);
			POS_HR:  n.hr  = wrap_inc(t.hr, HR_MAX);
			default: n     = t;
		endcase
		return n;
	endfunction

	// --------------------
	// clock time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_t <= '0;
		end else begin
			if (i_cmd.mode == MODE_SETUP) begin
				if (i_cmd.inc)
					clk_t <= hms_bump(clk_t, i_cmd.pos);  // frozen otherwise
			end else if (sec_tick) begin
				clk_t <= hms_step(clk_t);
			end
		end
	end

	// alarm time, set only in alarm mode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alm_t <= '0;
		else if (i_cmd.mode == MODE_ALARM && i_cmd.inc)
			alm_t <= hms_bump(alm_t, i_cmd.pos);
	end

	// shown time, one clk behind
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			show_q <= '0;
		else
			show_q <= (i_cmd.mode == MODE_ALARM) ? alm_t : clk_t;
	end

	assign match = (clk_t == alm_t);

	// latch holds until alarm_en drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alarm_q <= 1'b0;
		else
			alarm_q <= i_cmd.alarm_en & (alarm_q | match);
	end

	assign o_show  = show_q;
	assign o_alarm = alarm_q;

endmodule

`default_nettype wire

/* design/display_result.sv */
`default_nettype none

module display_result #(
	parameter int SCAN_DIV = 5_000
) (
	input  wire                clk,
	input  wire                rst_n,
	input  clock_pkg::hms_s    i_show,
	output clock_pkg::seg_t    o_seg,
	output clock_pkg::dig_en_t o_dig_en
);

	import clock_pkg::*;

	localparam logic [2:0] LAST_IDX = 3'd5;

	logic       scan_tick;
	logic [2:0] scan_idx;
	digit_t     digs [6];
	digit_t     cur_dig;

	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// --------------------
	// digit split
	function automatic digit_t tens_of(field_t f);
		return digit_t'(f / 6'd10);
	endfunction

	function automatic digit_t ones_of(field_t f);
		return digit_t'(f % 6'd10);
	endfunction

	always_comb begin
		digs[0] = ones_of(i_show.sec);
		digs[1] = tens_of(i_show.sec);
		digs[2] = ones_of(i_show.min);
		digs[3] = tens_of(i_show.min);
		digs[4] = ones_of(i_show.hr);
		digs[5] = tens_of(i_show.hr);
	end

	// --------------------
	// scan index, 0..5
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
		end else if (scan_tick) begin
			if (scan_idx >= LAST_IDX)
				scan_idx <= '0;
			else
				scan_idx <= scan_idx + 3'd1;
		end
	end

	assign cur_dig = digs[scan_idx];

	// blank on anything that is not a decimal digit
	assign o_seg    = (cur_dig <= 4'd9) ? SEG_TABLE[cur_dig] : '0;
	assign o_dig_en = ~(dig_en_t'(1) << scan_idx);  // one bit low

endmodule

`default_nettype wire

/* design/watch_top.sv */
`default_nettype none

module watch_top #(
	parameter int TICK_DIV   = 50_000_000,
	parameter int SAMPLE_DIV = 500_000,
	parameter int SCAN_DIV   = 5_000
) (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                i_sw_mode,
	input  wire                i_sw_pos,
	input  wire                i_sw_inc,
	input  wire                i_sw_alarm,
	output clock_pkg::seg_t    o_seg,
	output clock_pkg::dig_en_t o_dig_en,
	output logic               o_alarm
);

	import clock_pkg::*;

	cmd_s cmd;   // decode -> execute
	hms_s show;  // execute -> result

	button_decode #(.SAMPLE_DIV(SAMPLE_DIV)) u_button_decode (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sw_mode  (i_sw_mode),
		.i_sw_pos   (i_sw_pos),
		.i_sw_inc   (i_sw_inc),
		.i_sw_alarm (i_sw_alarm),
		.o_cmd      (cmd)
	);

	time_execute #(.TICK_DIV(TICK_DIV)) u_time_execute (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_cmd   (cmd),
		.o_show  (show),
		.o_alarm (o_alarm)
	);

	display_result #(.SCAN_DIV(SCAN_DIV)) u_display_result (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_show   (show),
		.o_seg    (o_seg),
		.o_dig_en (o_dig_en)
	);

endmodule

`default_nettype wire

/* tests/watch_properties.sv */
`default_nettype none

module watch_properties (
	input  wire                clk,
	input  wire                rst_n,
	input  clock_pkg::dig_en_t i_dig_en,
	input  clock_pkg::hms_s    i_show,
	input  wire                i_alarm_en,
	input  wire                i_alarm
);

	import clock_pkg::*;

	// --------------------
	// display scan
	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~i_dig_en))
		else $error("digit enable has not exactly one low bit");

	// shown fields in range
	a_show_range: assert property (@(posedge clk) disable iff (!rst_n)
		(i_show.sec <= SEC_MAX) && (i_show.min <= MIN_MAX) && (i_show.hr <= HR_MAX))
		else $error("shown time field out of range");

	// alarm drops one clk after the enable
	a_alarm_off: assert property (@(posedge clk) disable iff (!rst_n)
		!i_alarm_en |=> !i_alarm)
		else $error("alarm still high after enable cleared");

endmodule

bind watch_top watch_properties u_watch_properties (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_dig_en   (o_dig_en),
	.i_show     (show),
	.i_alarm_en (cmd.alarm_en),
	.i_alarm    (o_alarm)
);

`default_nettype wire

/* tests/watch_tb.sv */
`default_nettype none

module watch_tb;

	import clock_pkg::*;

	localparam int TICK_DIV   = 200;
	localparam int SAMPLE_DIV = 4;
	localparam int SCAN_DIV   = 2;
	localparam int HALF_CLK   = 20;
	localparam string DATA_FILE = "tests/watch_testdata.txt";

	logic    clk;
	logic    rst_n;
	logic    sw_mode;
	logic    sw_pos;
	logic    sw_inc;
	logic    sw_alarm;
	seg_t    seg;
	dig_en_t dig_en;
	logic    alarm;

	string   lines [$];
	longint  limit_clocks;

	// own copy of the a..g patterns for digits 0..9
	seg_t    digit_pattern [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	watch_top #(
		.TICK_DIV   (TICK_DIV),
		.SAMPLE_DIV (SAMPLE_DIV),
		.SCAN_DIV   (SCAN_DIV)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_sw_mode  (sw_mode),
		.i_sw_pos   (sw_pos),
		.i_sw_inc   (sw_inc),
		.i_sw_alarm (sw_alarm),
		.o_seg      (seg),
		.o_dig_en   (dig_en),
		.o_alarm    (alarm)
	);

	always #(HALF_CLK) clk = ~clk;

	task automatic stop_run(string why);
		$display("Test failures found");
		$fatal(1, "%s", why);
	endtask

	// --------------------
	// reference time rule with carries
	function automatic hms_s next_second(hms_s t);
		hms_s n;
		n = t;
		if (t.sec < 6'd59) begin
			n.sec = t.sec + 6'd1;
		end else begin
			n.sec = '0;
			if (t.min < 6'd59) begin
				n.min = t.min + 6'd1;
			end else begin
				n.min = '0;
				n.hr  = (t.hr < 6'd23) ? t.hr + 6'd1 : '0;
			end
		end
		return n;
	endfunction

	task automatic check_hms(string name, hms_s exp, hms_s act, bit running);
		bit ok;
		ok = (act == exp) || (running && act == next_second(exp));
		if (!ok) begin
			$display("CHECK FAILED %s: expected %02d:%02d:%02d, actual %02d:%02d:%02d",
				name, exp.hr, exp.min, exp.sec, act.hr, act.min, act.sec);
			stop_run("shown time mismatch");
		end
	endtask

	task automatic check_alarm(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s: expected alarm %b, actual alarm %b", name, exp, act);
			stop_run("alarm level mismatch");
		end
	endtask

	// map a pattern back to its digit
	task automatic check_seg(string name, seg_t pat, output digit_t d);
		int found;
		found = -1;
		for (int i = 0; i < 10; i++)
			if (digit_pattern[i] == pat)
				found = i;
		if (found < 0) begin
			$display("CHECK FAILED %s: segment pattern %b is not a decimal digit", name, pat);
			stop_run("bad segment pattern");
		end else begin
			d = digit_t'(found);
		end
	endtask

	// --------------------
	// watch the scan until all six digits were seen
	task automatic capture_display(string name, output hms_s shown);
		digit_t   digs [6];
		bit [5:0] seen;
		int       cycles;
		int       idx;
		int       lows;
		digit_t   d;
		seen   = '0;
		cycles = 0;
		while (seen != 6'b11_1111) begin
			@(negedge clk);
			cycles++;
			lows = 0;
			idx  = 0;
			for (int i = 0; i < 6; i++) begin
				if (dig_en[i] == 1'b0) begin
					lows++;
					idx = i;
				end
			end
			if (cycles > 8 * 6 * SCAN_DIV) begin
				stop_run("display scan did not visit all six digits");
			end else if (lows != 1) begin
				stop_run("digit enable does not have exactly one active bit");
			end else begin
				check_seg(name, seg, d);
				digs[idx]  = d;
				seen[idx]  = 1'b1;
			end
		end
		shown.sec = field_t'(digs[1] * 10 + digs[0]);
		shown.min = field_t'(digs[3] * 10 + digs[2]);
		shown.hr  = field_t'(digs[5] * 10 + digs[4]);
	endtask

	task automatic press_button(string btn, int count);
		for (int k = 0; k < count; k++) begin
			@(negedge clk);
			case (btn)
				"mode":  sw_mode  = 1'b1;
				"pos":   sw_pos   = 1'b1;
				"inc":   sw_inc   = 1'b1;
				"alarm": sw_alarm = 1'b1;
				default: stop_run({"unknown button name ", btn});
			endcase
			repeat (8 * SAMPLE_DIV) @(negedge clk);
			{sw_mode, sw_pos, sw_inc, sw_alarm} = 4'b0000;
			repeat (8 * SAMPLE_DIV) @(negedge clk);
		end
	endtask

	// steps on the second tick so no tick is lost between waits
	task automatic wait_ticks(int n);
		for (int k = 0; k < n; k++) begin
			@(negedge clk);
			while (i_dut.u_time_execute.sec_tick !== 1'b1)
				@(negedge clk);
		end
		repeat (2) @(negedge clk);  // time reg then shown reg
	endtask

	task automatic load_lines();
		int    fd;
		int    code;
		int    n;
		string line;
		string op;
		string name;
		string btn;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			stop_run("cannot open the test data file");
		end else begin
			limit_clocks = 1000;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.substr(0, 0) != "#" &&
					$sscanf(line, "%s %s", op, name) == 2) begin
					lines.push_back(line);
					limit_clocks += 100;  // capture and settle slack
					if (op == "wait" && $sscanf(line, "%s %s %d", op, name, n) == 3)
						limit_clocks += longint'(n) * TICK_DIV;
					if (op == "press" && $sscanf(line, "%s %s %s %d", op, name, btn, n) == 4)
						limit_clocks += longint'(n) * 20 * SAMPLE_DIV;
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------
	initial begin
		string op;
		string name;
		string btn;
		int    cnt;
		int    h;
		int    m;
		int    s;
		int    lvl;
		hms_s  exp;
		hms_s  act;

		clk      = 1'b0;
		rst_n    = 1'b0;
		sw_mode  = 1'b0;
		sw_pos   = 1'b0;
		sw_inc   = 1'b0;
		sw_alarm = 1'b0;

		load_lines();
		fork
			begin
				#(limit_clocks * 2 * HALF_CLK);
				stop_run("watchdog timeout, the test sequence took too long");
			end
		join_none

		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		foreach (lines[i]) begin
			cnt = $sscanf(lines[i], "%s %s", op, name);
			case (op)
				"press": begin
					if ($sscanf(lines[i], "%s %s %s %d", op, name, btn, cnt) != 4)
						stop_run({"malformed press line in test ", name});
					else
						press_button(btn, cnt);
				end
				"wait": begin
					if ($sscanf(lines[i], "%s %s %d", op, name, cnt) != 3)
						stop_run({"malformed wait line in test ", name});
					else
						wait_ticks(cnt);
				end
				"frozen", "running": begin
					if ($sscanf(lines[i], "%s %s %d %d %d", op, name, h, m, s) != 5) begin
						stop_run({"malformed time line in test ", name});
					end else begin
						exp.hr  = field_t'(h);
						exp.min = field_t'(m);
						exp.sec = field_t'(s);
						capture_display(name, act);
						check_hms(name, exp, act, op == "running");
					end
				end
				"alarm": begin
					if ($sscanf(lines[i], "%s %s %d", op, name, lvl) != 3) begin
						stop_run({"malformed alarm line in test ", name});
					end else begin
						@(negedge clk);
						check_alarm(name, logic'(lvl != 0), alarm);
					end
				end
				default: stop_run({"unknown opcode ", op});
			endcase
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/watch_testdata.txt */
# columns: opcode test_name values
# press btn count | wait ticks | frozen/running hr min sec | alarm level
running reset_time 0 0 0
alarm reset_alarm 0
press enter_setup mode 1
frozen setup_frozen 0 0 0
wait setup_hold 2
frozen setup_still 0 0 0
press set_sec inc 3
frozen sec_set 0 0 3
press sel_min pos 1
press set_min inc 58
frozen min_set 0 58 3
press sel_hr pos 1
press set_hr inc 1
frozen hr_set 1 58 3
press sel_sec pos 1
press sec_wrap inc 57
frozen sec_wrap_nocarry 1 58 0
press set_sec55 inc 55
frozen sec55 1 58 55
press leave_setup mode 1
press to_clock mode 1
wait run_sync 1
running run_start 1 58 56
wait run_minute 4
running minute_carry 1 59 0
wait run_hour 60
running hour_carry 2 0 0
press to_setup mode 1
press to_alarm mode 1
frozen alarm_shown 0 0 0
press alm_sec inc 20
press alm_sel pos 2
press alm_hr inc 2
press alm_back pos 1
frozen alarm_set 2 0 20
press alm_to_clock mode 1
press alarm_enable alarm 1
alarm alarm_armed 0
wait alarm_wait 14
alarm alarm_ring 1
wait alarm_hold 3
alarm alarm_held 1
press alarm_disable alarm 1
alarm alarm_cleared 0

/* watch.f */
design/clock_pkg.sv
design/tick_gen.sv
design/button_decode.sv
design/time_execute.sv
design/display_result.sv
design/watch_top.sv
tests/watch_properties.sv
tests/watch_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = watch_tb
FILELIST = watch.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
